// File: all.f
+incdir+.
relay_pkg.sv
relay_ctrl_if.sv
relay_sequencer.sv
relay_decode.sv
relay_regs.sv
relay_alu.sv
relay_top.sv
relay_tb_sva.sv
relay_tb.sv

// File: relay_alu.sv
// Eight-function ALU on B and C with zero, carry and sign flags
`timescale 1ns/100ps
`default_nettype none
`include "relay_defs.svh"

module relay_alu
	import relay_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	relay_ctrl_if.alu  ctrl,
	input  data_t      b,
	input  data_t      c,
	output data_t      alu_y
);

	logic cy;
	logic upd;

	always_comb
	begin
		cy = 1'b0;
		case (ctrl.alu_fn)
			ALU_ADD: {cy, alu_y} = {1'b0, b} + {1'b0, c};
			ALU_INC: {cy, alu_y} = {1'b0, b} + 1'b1;
			ALU_AND: alu_y = b & c;
			ALU_OR:  alu_y = b | c;
			ALU_XOR: alu_y = b ^ c;
			ALU_NOT: alu_y = ~b;
			ALU_SHL: {cy, alu_y} = {b, b[`RELAY_DATA_W-1]}; // MSB out to carry and bit 0
			default: alu_y = '0;
		endcase
	end

	// Flags follow only a real ALU result being loaded
	assign upd = (ctrl.ld_a | ctrl.ld_d) && (ctrl.alu_fn != ALU_CLR);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ctrl.zero <= 1'b0;
			ctrl.carry <= 1'b0;
			ctrl.sign <= 1'b0;
		end
		else if (upd)
		begin
			ctrl.zero <= (alu_y == '0);
			ctrl.carry <= cy;
			ctrl.sign <= alu_y[`RELAY_DATA_W-1];
		end
	end

endmodule

`default_nettype wire

// File: relay_ctrl_if.sv
// Control strobes from the decoder to the register file and ALU, with
// flags, instruction byte and ALU operands coming back
`timescale 1ns/100ps
`default_nettype none

interface relay_ctrl_if
	import relay_pkg::*;
();
	// Register loads
	logic ld_a, ld_b, ld_c, ld_d;
	logic ld_m1, ld_m2, ld_x, ld_y;
	logic ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst;

	// Data bus and address bus selects
	logic sel_a, sel_b, sel_c, sel_d;
	logic sel_m1, sel_m2, sel_x, sel_y;
	logic sel_pc, sel_m, sel_j, sel_xy, sel_inc;

	logic    imm_en;
	data_t   imm;
	alu_fn_t alu_fn;

	logic  zero, carry, sign;
	data_t inst;
	data_t reg_b, reg_c; // ALU operands

	modport dec (
		output ld_a, ld_b, ld_c, ld_d, ld_m1, ld_m2, ld_x, ld_y,
		output ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst,
		output sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y,
		output sel_pc, sel_m, sel_j, sel_xy, sel_inc,
		output imm_en, imm, alu_fn,
		input  zero, carry, sign, inst
	);

	modport regs (
		input  ld_a, ld_b, ld_c, ld_d, ld_m1, ld_m2, ld_x, ld_y,
		input  ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst,
		input  sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y,
		input  sel_pc, sel_m, sel_j, sel_xy, sel_inc,
		input  imm_en, imm, alu_fn,
		output inst, reg_b, reg_c
	);

	modport alu (
		input  alu_fn, ld_a, ld_d,
		output zero, carry, sign
	);

endinterface

`default_nettype wire

// File: relay_decode.sv
// Instruction decoder, turns the step number and instruction byte into
// load, select, immediate, ALU and memory strobes
`timescale 1ns/100ps
`default_nettype none
`include "relay_defs.svh"

module relay_decode
	import relay_pkg::*;
(
	input  step_t         step,
	relay_ctrl_if.dec     ctrl,
	output op_class_t     op_class,
	output logic          mem_read,
	output logic          mem_write,
	output logic          halt
);

	data_t      inst;
	logic [7:0] ld_r;  // Indexed by reg_sel_t
	logic [7:0] sel_r;
	reg_sel_t   mov_dst;
	reg_sel_t   mov_src;
	reg_sel_t   setab_dst;
	reg_sel_t   alu_dst;
	reg_sel_t   ldst_reg;
	logic       jump_j;
	logic       take;

	assign inst      = ctrl.inst;
	assign mov_dst   = reg_sel_t'(inst[5:3]);
	assign mov_src   = reg_sel_t'(inst[2:0]);
	assign setab_dst = inst[5] ? REG_B : REG_A;
	assign alu_dst   = inst[3] ? REG_D : REG_A;
	assign ldst_reg  = reg_sel_t'({1'b0, inst[1:0]});
	assign jump_j    = inst[5];

	assign ctrl.imm = {{3{inst[4]}}, inst[4:0]}; // SETAB sign extension

	// Branch test, no condition bits means always
	assign take = (inst[4:1] == 4'b0000) |
		(inst[4] & ctrl.sign) | (inst[3] & ctrl.carry) |
		(inst[2] & ctrl.zero) | (inst[1] & ~ctrl.zero);

	always_comb
	begin
		casez (inst)
			`RELAY_OP_HALT:   op_class = OP_HALT;
			`RELAY_PAT_MOV8:  op_class = OP_MOV8;
			`RELAY_PAT_SETAB: op_class = OP_SETAB;
			`RELAY_PAT_ALU:   op_class = OP_ALU;
			`RELAY_PAT_LDST:  op_class = OP_LDST;
			`RELAY_PAT_MOV16: op_class = OP_MOV16;
			`RELAY_PAT_INC:   op_class = OP_INC;
			default:          op_class = OP_GOTO;
		endcase
	end

	assign halt = (op_class == OP_HALT) && step[9];

	always_comb
	begin
		ld_r = '0;
		sel_r = '0;
		ctrl.ld_j1 = 1'b0;
		ctrl.ld_j2 = 1'b0;
		ctrl.ld_xy = 1'b0;
		ctrl.ld_inst = 1'b0;
		ctrl.ld_inc = 1'b0;
		ctrl.sel_pc = 1'b0;
		ctrl.sel_m = 1'b0;
		ctrl.sel_j = 1'b0;
		ctrl.sel_xy = 1'b0;
		ctrl.imm_en = 1'b0;
		ctrl.alu_fn = ALU_CLR;
		mem_read = 1'b0;
		mem_write = 1'b0;

		// Fetch
		ctrl.sel_pc = step[1] | step[2] | step[3];
		mem_read = step[1] | step[2] | step[3];
		ctrl.ld_inst = step[2];
		ctrl.ld_inc = step[2];

		// PC past the opcode byte
		ctrl.sel_inc = (op_class != OP_HALT) && (step[5] | step[6]);
		ctrl.ld_pc = (op_class != OP_HALT) && step[5];

		case (op_class)
			OP_MOV8:
			begin
				ld_r[mov_dst] = step[5];
				sel_r[mov_src] = step[5] | step[6];
			end
			OP_SETAB:
			begin
				ctrl.imm_en = step[4] | step[5] | step[6];
				ld_r[setab_dst] = step[5];
			end
			OP_ALU:
			begin
				if (step[4] | step[5] | step[6])
					ctrl.alu_fn = alu_fn_t'(inst[2:0]);
				ld_r[alu_dst] = step[5];
			end
			OP_LDST:
			begin
				ctrl.sel_m = step[8] | step[9] | step[10];
				if (inst[3])
				begin
					sel_r[ldst_reg] = step[8] | step[9] | step[10];
					mem_write = step[9]; // Data settled one step before
				end
				else
				begin
					mem_read = step[8] | step[9] | step[10];
					ld_r[ldst_reg] = step[9];
				end
			end
			OP_MOV16:
			begin
				if (inst == `RELAY_OP_RET)
				begin
					ctrl.sel_xy = step[8];
					ctrl.ld_pc |= step[8];
				end
				else
				begin
					ctrl.sel_m = step[8] & ~inst[2];
					ctrl.sel_j = step[8] & inst[2];
					ctrl.ld_xy = step[8];
				end
			end
			OP_INC:
			begin
				ctrl.sel_xy = step[8] | step[9];
				ctrl.ld_inc |= step[8];
				ctrl.sel_inc |= step[11] | step[12];
				ctrl.ld_xy = step[11];
			end
			OP_GOTO:
			begin
				// Two address bytes, high then low
				ctrl.sel_pc |= step[8] | step[9] | step[10] | step[15] | step[16] | step[17];
				mem_read |= step[8] | step[9] | step[10] | step[15] | step[16] | step[17];
				ld_r[REG_M1] = step[9] & ~jump_j;
				ctrl.ld_j1 = step[9] & jump_j;
				ld_r[REG_M2] = step[16] & ~jump_j;
				ctrl.ld_j2 = step[16] & jump_j;
				ctrl.ld_inc |= step[9] | step[16];
				ctrl.sel_inc |= step[12] | step[13] | step[19] | step[20];
				ctrl.ld_pc |= step[12] | step[19];
				ctrl.ld_xy = step[19] & inst[0]; // Return address for a call
				if ((step[22] | step[23]) && take)
				begin
					ctrl.sel_m = ~jump_j;
					ctrl.sel_j = jump_j;
					ctrl.ld_pc |= step[22];
				end
			end
			default:
				; // HALT keeps everything low
		endcase
	end

	assign ctrl.ld_a   = ld_r[REG_A];
	assign ctrl.ld_b   = ld_r[REG_B];
	assign ctrl.ld_c   = ld_r[REG_C];
	assign ctrl.ld_d   = ld_r[REG_D];
	assign ctrl.ld_m1  = ld_r[REG_M1];
	assign ctrl.ld_m2  = ld_r[REG_M2];
	assign ctrl.ld_x   = ld_r[REG_X];
	assign ctrl.ld_y   = ld_r[REG_Y];
	assign ctrl.sel_a  = sel_r[REG_A];
	assign ctrl.sel_b  = sel_r[REG_B];
	assign ctrl.sel_c  = sel_r[REG_C];
	assign ctrl.sel_d  = sel_r[REG_D];
	assign ctrl.sel_m1 = sel_r[REG_M1];
	assign ctrl.sel_m2 = sel_r[REG_M2];
	assign ctrl.sel_x  = sel_r[REG_X];
	assign ctrl.sel_y  = sel_r[REG_Y];

endmodule

`default_nettype wire

// File: relay_defs.svh
// Bus widths, the class patterns of the instruction byte and the two
// full-byte opcodes
`ifndef RELAY_DEFS_SVH
`define RELAY_DEFS_SVH

`define RELAY_DATA_W 8
`define RELAY_ADDR_W 16

// Class patterns, matched with casez on the instruction register
// MOV8   00 ddd sss        SETAB  01 r iiiii, r=1 loads B
// ALU    1000 r fff, r=1 loads D
// LDST   1001 s 0 rr, s=1 stores, rr picks A to D
// MOV16  1010 0 j 00, j=1 copies J1:J2 into XY, else M1:M2
// INC    1011 0000, increments XY
// GOTO   11 d s c z n k, d=1 goes through J, k=1 is a call
`define RELAY_PAT_MOV8  8'b00??????
`define RELAY_PAT_SETAB 8'b01??????
`define RELAY_PAT_ALU   8'b1000????
`define RELAY_PAT_LDST  8'b1001????
`define RELAY_PAT_MOV16 8'b1010????
`define RELAY_PAT_INC   8'b1011????
`define RELAY_PAT_GOTO  8'b11??????

// Both sit inside the MOV16 pattern and are checked before it
`define RELAY_OP_HALT 8'hAE
`define RELAY_OP_RET  8'hAA

`endif

// File: relay_pkg.sv
// Shared types: bus values, one-hot step, instruction class, register
// select and ALU function codes
`default_nettype none
`include "relay_defs.svh"

package relay_pkg;

	typedef logic [`RELAY_DATA_W-1:0] data_t;
	typedef logic [`RELAY_ADDR_W-1:0] addr_t;

	typedef logic [24:1] step_t; // Bit n is step n
	localparam step_t STEP_FIRST = step_t'(1);

	typedef enum logic [3:0] {
		OP_MOV8,
		OP_SETAB,
		OP_ALU,
		OP_LDST,
		OP_MOV16,
		OP_INC,
		OP_GOTO,
		OP_HALT
	} op_class_t;

	// Same order as the register fields of MOV8
	typedef enum logic [2:0] {
		REG_A, REG_B, REG_C, REG_D,
		REG_M1, REG_M2, REG_X, REG_Y
	} reg_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_INC,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOT,
		ALU_SHL, // Rotate left through carry out
		ALU_CLR  // Idle
	} alu_fn_t;

endpackage

`default_nettype wire

// File: relay_regs.sv
// Register file with the data and address buses and the increment unit
`timescale 1ns/100ps
`default_nettype none
`include "relay_defs.svh"

module relay_regs
	import relay_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	relay_ctrl_if.regs  ctrl,
	input  data_t       alu_y,
	input  data_t       mem_rdata,
	output addr_t       mem_addr,
	output data_t       mem_wdata
);

	data_t a_q, b_q, c_q, d_q;
	data_t m1_q, m2_q, x_q, y_q;
	data_t j1_q, j2_q, inst_q;
	addr_t pc_q, inc_q;
	data_t data_bus;
	addr_t addr_bus;

	always_comb
	begin
		if (ctrl.imm_en)
			data_bus = ctrl.imm;
		else if (ctrl.sel_a)
			data_bus = a_q;
		else if (ctrl.sel_b)
			data_bus = b_q;
		else if (ctrl.sel_c)
			data_bus = c_q;
		else if (ctrl.sel_d)
			data_bus = d_q;
		else if (ctrl.sel_m1)
			data_bus = m1_q;
		else if (ctrl.sel_m2)
			data_bus = m2_q;
		else if (ctrl.sel_x)
			data_bus = x_q;
		else if (ctrl.sel_y)
			data_bus = y_q;
		else if (ctrl.alu_fn != ALU_CLR)
			data_bus = alu_y;
		else
			data_bus = mem_rdata; // Zero unless a read is on
	end

	// Wired-OR of the address sources
	assign addr_bus = ({`RELAY_ADDR_W{ctrl.sel_pc}} & pc_q) |
		({`RELAY_ADDR_W{ctrl.sel_m}} & {m1_q, m2_q}) |
		({`RELAY_ADDR_W{ctrl.sel_j}} & {j1_q, j2_q}) |
		({`RELAY_ADDR_W{ctrl.sel_xy}} & {x_q, y_q}) |
		({`RELAY_ADDR_W{ctrl.sel_inc}} & inc_q);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			a_q <= '0;
			b_q <= '0;
			c_q <= '0;
			d_q <= '0;
			m1_q <= '0;
			m2_q <= '0;
			x_q <= '0;
			y_q <= '0;
			j1_q <= '0;
			j2_q <= '0;
			inst_q <= '0;
			pc_q <= '0;
			inc_q <= '0;
		end
		else
		begin
			if (ctrl.ld_a)
				a_q <= data_bus;
			if (ctrl.ld_b)
				b_q <= data_bus;
			if (ctrl.ld_c)
				c_q <= data_bus;
			if (ctrl.ld_d)
				d_q <= data_bus;
			if (ctrl.ld_m1)
				m1_q <= data_bus;
			if (ctrl.ld_m2)
				m2_q <= data_bus;
			if (ctrl.ld_x)
				x_q <= data_bus;
			if (ctrl.ld_y)
				y_q <= data_bus;
			if (ctrl.ld_xy)
				{x_q, y_q} <= addr_bus; // From M, J or the incrementer
			if (ctrl.ld_j1)
				j1_q <= data_bus;
			if (ctrl.ld_j2)
				j2_q <= data_bus;
			if (ctrl.ld_inst)
				inst_q <= data_bus;
			if (ctrl.ld_pc)
				pc_q <= addr_bus;
			if (ctrl.ld_inc)
				inc_q <= addr_bus + addr_t'(1);
		end
	end

	assign mem_addr   = addr_bus;
	assign mem_wdata  = data_bus;
	assign ctrl.inst  = inst_q;
	assign ctrl.reg_b = b_q;
	assign ctrl.reg_c = c_q;

endmodule

`default_nettype wire

// File: relay_sequencer.sv
// One-hot step sequencer, instruction length set by the decoded class
`timescale 1ns/100ps
`default_nettype none

module relay_sequencer
	import relay_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  op_class_t op_class,
	output step_t     step
);

	logic last;
	logic hold;

	// Last step of the running instruction
	always_comb
	begin
		case (op_class)
			OP_LDST, OP_MOV16, OP_INC:
				last = step[12];
			OP_GOTO:
				last = step[24];
			OP_HALT:
				last = 1'b0; // Never wraps
			default:
				last = step[8];
		endcase
	end

	assign hold = (op_class == OP_HALT) && step[9];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			step <= STEP_FIRST;
		end
		else if (last)
		begin
			step <= STEP_FIRST;
		end
		else if (!hold)
		begin
			step <= step << 1;
		end
	end

endmodule

`default_nettype wire

// File: relay_tb.sv
// Testbench for relay_top with memory model, ISA reference and store checks
`timescale 1ns/100ps
`default_nettype none
`include "relay_defs.svh"

module relay_tb
	import relay_pkg::*;
();

	logic  clk;
	logic  arst_n;
	data_t mem_rdata;
	addr_t mem_addr;
	data_t mem_wdata;
	logic  mem_read, mem_write, halt;

	data_t mem [256];
	addr_t exp_addr [$];
	data_t exp_data [$];
	string test_name;
	int    pos;
	int    errors = 0;
	int    test_errs;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    cycles = 0;
	int    limit = 100;

	relay_top relay_top_inst (
		.clk(clk), .arst_n(arst_n), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write), .halt(halt)
	);

	bind relay_top relay_tb_sva relay_tb_sva_inst (
		.clk(clk), .arst_n(arst_n),
		.addr_sel({ctrl.sel_pc, ctrl.sel_m, ctrl.sel_j, ctrl.sel_xy, ctrl.sel_inc}),
		.mem_read(mem_read), .mem_write(mem_write), .halt(halt)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk;

	assign mem_rdata = mem[mem_addr[7:0]]; // Combinational read

	always @(posedge clk)
	begin
		if (arst_n && mem_write)
			mem[mem_addr[7:0]] <= mem_wdata;
	end

	function automatic void report_error(string msg);
		$display("Error in %s: %s", test_name, msg);
		errors++;
		test_errs++;
	endfunction

	task automatic check_data(string name, data_t exp, data_t act);
		if (exp !== act)
		begin
			$display("Mismatch in %s: expected %02h, actual %02h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (exp !== act)
		begin
			$display("Mismatch in %s: expected %04h, actual %04h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	// Each store is compared with the next expected one
	always @(posedge clk)
	begin
		if (arst_n && mem_write)
		begin
			if (exp_addr.size() == 0)
				report_error("store happened with no store expected");
			else
			begin
				check_addr(test_name, exp_addr.pop_front(), mem_addr);
				check_data(test_name, exp_data.pop_front(), mem_wdata);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles in %s", cycles, test_name);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ISA-level model of the loaded program that fills the expected stores
	function automatic int ref_run();
		data_t m [256];
		data_t r [8]; // A B C D M1 M2 X Y
		data_t j1, j2, op, res, hi, lo;
		addr_t pc, a;
		logic  z, cy, sg, c_new, take;
		int    n;
		m = mem;
		r = '{default: '0};
		j1 = '0;
		j2 = '0;
		pc = '0;
		{z, cy, sg} = 3'b000;
		n = 0;
		while (n < 2000)
		begin
			op = m[pc[7:0]];
			pc = pc + 1;
			n++;
			if (op == `RELAY_OP_HALT)
				return n;
			casez (op)
				8'b00??????: r[op[5:3]] = r[op[2:0]];
				8'b01??????: r[{2'b00, op[5]}] = {{3{op[4]}}, op[4:0]};
				8'b1000????:
				begin
					c_new = 1'b0;
					case (op[2:0])
						3'd0: {c_new, res} = {1'b0, r[1]} + {1'b0, r[2]};
						3'd1: {c_new, res} = {1'b0, r[1]} + 9'd1;
						3'd2: res = r[1] & r[2];
						3'd3: res = r[1] | r[2];
						3'd4: res = r[1] ^ r[2];
						3'd5: res = ~r[1];
						3'd6: {c_new, res} = {r[1][7], r[1][6:0], r[1][7]};
						default: res = '0;
					endcase
					r[op[3] ? 3 : 0] = res;
					if (op[2:0] != 3'd7)
						{z, cy, sg} = {res == 8'd0, c_new, res[7]};
				end
				8'b1001????:
				begin
					a = {r[4], r[5]};
					if (op[3])
					begin
						exp_addr.push_back(a);
						exp_data.push_back(r[op[1:0]]);
						m[a[7:0]] = r[op[1:0]];
					end
					else
						r[op[1:0]] = m[a[7:0]];
				end
				8'b1010????:
				begin
					if (op == `RELAY_OP_RET)
						pc = {r[6], r[7]};
					else if (op[2])
						{r[6], r[7]} = {j1, j2};
					else
						{r[6], r[7]} = {r[4], r[5]};
				end
				8'b1011????: {r[6], r[7]} = {r[6], r[7]} + 16'd1;
				default:
				begin
					hi = m[pc[7:0]];
					lo = m[8'(pc + 1)];
					pc = pc + 2;
					if (op[5])
						{j1, j2} = {hi, lo};
					else
						{r[4], r[5]} = {hi, lo};
					if (op[0])
						{r[6], r[7]} = pc; // Call return address
					take = (op[4:1] == 4'b0000) || (op[4] && sg) || (op[3] && cy) ||
						(op[2] && z) || (op[1] && !z);
					if (take)
						pc = op[5] ? {j1, j2} : {r[4], r[5]};
				end
			endcase
		end
		report_error("reference program never reached HALT");
		return n;
	endfunction

	task automatic emit(data_t b);
		mem[pos] = b;
		pos++;
	endtask

	task automatic emit_setab(logic to_b, logic [4:0] imm);
		emit({2'b01, to_b, imm});
	endtask

	task automatic emit_mov(logic [2:0] dst, logic [2:0] src);
		emit({2'b00, dst, src});
	endtask

	task automatic emit_store(logic [1:0] rr);
		emit({6'b100110, rr});
	endtask

	// Points M1:M2 at 00F0 to 00FF through A
	task automatic point_m(logic [3:0] lo);
		emit_setab(1'b0, 5'd0);
		emit_mov(3'd4, 3'd0);
		emit_setab(1'b0, {1'b1, lo});
		emit_mov(3'd5, 3'd0);
	endtask

	task automatic start_program(string name);
		test_name = name;
		for (int i = 0; i < 256; i++)
			mem[i] = data_t'(i) ^ 8'h5A;
		pos = 0;
	endtask

	task automatic run_program();
		int n;
		test_errs = 0;
		exp_addr.delete();
		exp_data.delete();
		n = ref_run();
		limit += 24 * n;
		@(negedge clk);
		arst_n = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(posedge clk);
		if (mem_write || halt)
			report_error("mem_write or halt high right after reset");
		if (!mem_read)
			report_error("no fetch read in the first cycle after reset");
		check_addr(test_name, addr_t'(0), mem_addr);
		while (!halt)
			@(posedge clk);
		repeat (50)
		begin
			@(posedge clk);
			if (mem_read || mem_write)
				report_error("memory access after halt");
		end
		if (exp_addr.size() != 0)
			report_error("expected stores never happened");
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("Test %s: %0d instructions, %0d errors", test_name, n, test_errs);
	endtask

	initial
	begin
		logic [2:0] dst;
		logic       to_b;
		int         p, k, tidx;
		arst_n = 1'b0;
		void'($urandom(32'hd9a842db));

		start_program("setab_mov");
		for (int i = 0; i < 4; i++)
		begin
			point_m(4'(i));
			to_b = 1'($urandom);
			dst = 3'($urandom % 4);
			emit_setab(to_b, 5'($urandom));
			emit_mov(dst, {2'b00, to_b});
			emit_store(dst[1:0]);
		end
		emit(`RELAY_OP_HALT);
		run_program();

		start_program("alu_branch");
		for (int fn = 0; fn < 7; fn++)
		begin
			point_m(4'(fn));
			emit_setab(1'b1, 5'($urandom));
			emit_setab(1'b0, 5'($urandom));
			emit_mov(3'd2, 3'd0);
			to_b = 1'($urandom); // Picks D as destination
			emit({4'b1000, to_b, 3'(fn)});
			emit_store(to_b ? 2'd3 : 2'd0);
			p = pos;
			emit({3'b111, 4'b0001 << ($urandom % 4), 1'b0});
			emit(8'h00);
			emit(8'(p + 8));
			emit_setab(1'b0, 5'd1);
			emit_store(2'd0);
			emit(8'hE0);
			emit(8'h00);
			emit(8'(p + 10));
			emit_setab(1'b0, 5'd2);
			emit_store(2'd0);
		end
		emit(`RELAY_OP_HALT);
		run_program();

		start_program("xy_return");
		point_m(4'($urandom));
		emit(8'hF0); // Sign branch that only loads J after reset
		emit(8'h00);
		tidx = pos;
		emit(8'h00);
		emit(8'hA4);
		k = 1 + $urandom % 4;
		repeat (k)
			emit(8'hB0);
		emit_mov(3'd1, 3'd6);
		emit_store(2'd1);
		emit_mov(3'd1, 3'd7);
		emit_store(2'd1);
		emit(`RELAY_OP_RET);
		repeat ($urandom % 3)
			emit(`RELAY_OP_HALT);
		mem[tidx] = 8'(pos - k);
		emit_setab(1'b0, 5'($urandom));
		emit_store(2'd0);
		emit(8'hA0);
		emit(8'hB0);
		emit_mov(3'd1, 3'd7);
		emit_store(2'd1);
		emit(`RELAY_OP_HALT);
		run_program();

		start_program("goto_call");
		point_m(4'($urandom));
		p = pos;
		k = $urandom % 3;
		emit(8'hE0);
		emit(8'h00);
		emit(8'(p + 3 + k));
		repeat (k)
			emit(`RELAY_OP_HALT);
		emit_setab(1'b0, 5'($urandom));
		emit_store(2'd0);
		p = pos;
		emit(8'hE1);
		emit(8'h00);
		emit(8'(p + 6));
		emit_setab(1'b0, 5'($urandom));
		emit_store(2'd0);
		emit(`RELAY_OP_HALT);
		emit_setab(1'b0, 5'($urandom));
		emit_store(2'd0);
		emit(`RELAY_OP_RET);
		run_program();

		start_program("halt_only");
		emit(`RELAY_OP_HALT);
		run_program();

		errors += relay_top_inst.relay_tb_sva_inst.fail_count;
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: relay_tb_sva.sv
// Bound checks on address select exclusivity, memory strobes and halt
`timescale 1ns/100ps
`default_nettype none

module relay_tb_sva (
	input wire       clk,
	input wire       arst_n,
	input wire [4:0] addr_sel, // PC, M, J, XY, INC
	input wire       mem_read,
	input wire       mem_write,
	input wire       halt
);

	int fail_count = 0;

	a_one_addr_sel: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(addr_sel))
	else
	begin
		$error("more than one address select active");
		fail_count++;
	end

	a_no_read_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read && mem_write))
	else
	begin
		$error("memory read and write together");
		fail_count++;
	end

	a_halt_holds: assert property (@(posedge clk) disable iff (!arst_n) halt |=> halt)
	else
	begin
		$error("halt dropped without reset");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: relay_top.sv
// Top level, sequencer, decoder, registers and ALU on plain memory ports
`timescale 1ns/100ps
`default_nettype none
`include "relay_defs.svh"

module relay_top
	import relay_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`RELAY_DATA_W-1:0] mem_rdata,
	output logic [`RELAY_ADDR_W-1:0] mem_addr,
	output logic [`RELAY_DATA_W-1:0] mem_wdata,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic                     halt
);

	step_t     step;
	op_class_t op_class;
	data_t     rdata_gated;
	data_t     alu_y;

	relay_ctrl_if ctrl ();

	assign rdata_gated = mem_read ? mem_rdata : '0; // Memory drives the bus only on reads

	relay_sequencer relay_sequencer_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.op_class (op_class),
		.step     (step)
	);

	relay_decode relay_decode_inst (
		.step      (step),
		.ctrl      (ctrl),
		.op_class  (op_class),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.halt      (halt)
	);

	relay_regs relay_regs_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctrl      (ctrl),
		.alu_y     (alu_y),
		.mem_rdata (rdata_gated),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	relay_alu relay_alu_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.ctrl   (ctrl),
		.b      (ctrl.reg_b),
		.c      (ctrl.reg_c),
		.alu_y  (alu_y)
	);

endmodule

`default_nettype wire
